//--- rtl/eeprom_pkg.sv
package eeprom_pkg;

    // Memory geometry, 3 block bits plus one address byte
    localparam int addr_w = 11;

    // Device-type nibble in the control byte
    localparam logic [3:0] dev_code = 4'b1010;

    // One memory request from the host side
    typedef struct packed {
        logic              write;
        logic [addr_w-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_cmd_t;

    // Completion of one request
    typedef struct packed {
        logic [7:0] rdata;
        // Cleared by any missing acknowledge
        logic       ack_ok;
    } eeprom_rsp_t;

    // Open-drain pull-downs of one bus agent
    typedef struct packed {
        logic clk_low;
        logic data_low;
    } bus_drive_t;

    // Resolved line levels
    typedef struct packed {
        logic clk;
        logic data;
    } bus_line_t;

    // Bit-level operations of the bus engine
    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_write,
        op_read
    } bit_op_e;

endpackage

//--- rtl/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine
    import eeprom_pkg::*;
#(
    parameter int quarter_div = 4
)
(
    input  logic       scl,
    input  logic       arst_n,
    input  bit_op_e    bit_op,
    input  logic       bit_in,
    input  logic       bit_go,
    output bus_drive_t drive,
    input  bus_line_t  line,
    output logic       bit_out,
    output logic       bit_done
);

    localparam int cnt_w = $clog2(quarter_div + 1);
    localparam logic [cnt_w-1:0] last_q = cnt_w'(quarter_div - 1);

    logic             run;
    bit_op_e          op_q;
    logic             in_q;
    logic [1:0]       phase;
    logic [cnt_w-1:0] qcnt;
    logic             q_end;

    // Pull-downs for one quarter of an operation
    function automatic bus_drive_t shape(bit_op_e op, logic b, logic [1:0] ph);
        bus_drive_t d;
        // clk is high in the two middle quarters
        d.clk_low = (ph == 2'd0) || (ph == 2'd3);
        case (op)
            op_start:
            begin
                // data falls while clk is high
                d.data_low = (ph >= 2'd2);
            end
            op_stop:
            begin
                // data rises while clk is high, clk stays released after
                d.clk_low  = (ph == 2'd0);
                d.data_low = (ph <= 2'd1);
            end
            op_write:
            begin
                d.data_low = !b;
            end
            default:
            begin
                d.data_low = 1'b0;
            end
        endcase
        return d;
    endfunction

    assign q_end    = (qcnt == last_q);
    assign bit_done = run && q_end && (phase == 2'd3);

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            run     <= 1'b0;
            op_q    <= op_start;
            in_q    <= 1'b0;
            phase   <= 2'd0;
            qcnt    <= '0;
            drive   <= '0;
            bit_out <= 1'b0;
        end
        else if (!run)
        begin
            if (bit_go)
            begin
                run   <= 1'b1;
                op_q  <= bit_op;
                in_q  <= bit_in;
                phase <= 2'd0;
                qcnt  <= '0;
                drive <= shape(bit_op, bit_in, 2'd0);
            end
        end
        else if (q_end)
        begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
            if (phase == 2'd3)
                run <= 1'b0;
            else
                drive <= shape(op_q, in_q, phase + 2'd1);
            // Middle of the clk-high window
            if (phase == 2'd1)
                bit_out <= line.data;
        end
        else
        begin
            qcnt <= qcnt + 1'b1;
        end
    end

endmodule

//--- rtl/eeprom_master.sv
`timescale 1ns/1ps

module eeprom_master
    import eeprom_pkg::*;
(
    input  logic        scl,
    input  logic        arst_n,
    input  eeprom_cmd_t cmd,
    input  logic        cmd_valid,
    output logic        busy,
    output eeprom_rsp_t rsp,
    output logic        done,
    output bit_op_e     bit_op,
    output logic        bit_in,
    output logic        bit_go,
    input  logic        bit_out,
    input  logic        bit_done
);

    typedef enum logic [3:0] {
        m_idle,
        m_start,
        m_ctrl,
        m_addr,
        m_wdata,
        m_rstart,
        m_ctrl_rd,
        m_rdata,
        m_stop
    } state_e;

    state_e      state;
    logic [3:0]  bit_idx;
    logic        launch;
    eeprom_cmd_t cmd_q;
    logic [7:0]  tx_byte;
    logic        ack_slot;

    // Ninth bit of every byte
    assign ack_slot = (bit_idx == 4'd8);
    assign bit_go   = launch;

    always_comb
    begin
        case (state)
            m_ctrl:    tx_byte = {dev_code, cmd_q.addr[addr_w-1:8], 1'b0};
            m_addr:    tx_byte = cmd_q.addr[7:0];
            m_wdata:   tx_byte = cmd_q.wdata;
            m_ctrl_rd: tx_byte = {dev_code, cmd_q.addr[addr_w-1:8], 1'b1};
            default:   tx_byte = 8'h00;
        endcase
    end

    always_comb
    begin
        bit_in = 1'b1;
        case (state)
            m_start, m_rstart:
                bit_op = op_start;
            m_stop:
                bit_op = op_stop;
            m_ctrl, m_addr, m_wdata, m_ctrl_rd:
            begin
                bit_op = ack_slot ? op_read : op_write;
                // MSB first
                bit_in = tx_byte[3'(4'd7 - bit_idx)];
            end
            m_rdata:
                // No-acknowledge after the single read byte
                bit_op = ack_slot ? op_write : op_read;
            default:
                bit_op = op_start;
        endcase
    end

    always_ff @(posedge scl)
    begin
        if (state == m_idle && cmd_valid)
            cmd_q <= cmd;
    end

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= m_idle;
            bit_idx <= 4'd0;
            launch  <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            rsp     <= '0;
        end
        else
        begin
            launch <= 1'b0;
            done   <= 1'b0;
            if (state == m_idle)
            begin
                if (cmd_valid)
                begin
                    state      <= m_start;
                    bit_idx    <= 4'd0;
                    launch     <= 1'b1;
                    busy       <= 1'b1;
                    rsp.rdata  <= 8'h00;
                    rsp.ack_ok <= 1'b1;
                end
            end
            else if (bit_done)
            begin
                launch <= 1'b1;
                case (state)
                    m_start:  state <= m_ctrl;
                    m_rstart: state <= m_ctrl_rd;
                    m_ctrl, m_addr, m_wdata, m_ctrl_rd:
                    begin
                        if (!ack_slot)
                        begin
                            bit_idx <= bit_idx + 4'd1;
                        end
                        else
                        begin
                            bit_idx <= 4'd0;
                            // Slave leaves data high on a missing ack
                            if (bit_out)
                                rsp.ack_ok <= 1'b0;
                            case (state)
                                m_ctrl:  state <= m_addr;
                                m_addr:  state <= cmd_q.write ? m_wdata : m_rstart;
                                m_wdata: state <= m_stop;
                                default: state <= m_rdata;
                            endcase
                        end
                    end
                    m_rdata:
                    begin
                        if (!ack_slot)
                        begin
                            rsp.rdata <= {rsp.rdata[6:0], bit_out};
                            bit_idx   <= bit_idx + 4'd1;
                        end
                        else
                        begin
                            bit_idx <= 4'd0;
                            state   <= m_stop;
                        end
                    end
                    default:
                    begin
                        launch <= 1'b0;
                        busy   <= 1'b0;
                        done   <= 1'b1;
                        state  <= m_idle;
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/eeprom_slave.sv
`timescale 1ns/1ps

module eeprom_slave
    import eeprom_pkg::*;
(
    input  logic      scl,
    input  logic      arst_n,
    input  bus_line_t line,
    output logic      data_low
);

    typedef enum logic [2:0] {
        s_idle,
        s_ctrl,
        s_addr,
        s_data,
        s_send,
        s_wait
    } state_e;

    state_e            state;
    bus_line_t         sync_m;
    bus_line_t         sync_s;
    bus_line_t         line_d;
    logic              clk_rise;
    logic              clk_fall;
    logic              start_det;
    logic              stop_det;
    logic [3:0]        bit_cnt;
    logic              byte_end;
    logic              slot_end;
    logic              send_step;
    logic              code_ok;
    logic [7:0]        sh;
    logic [7:0]        out_sh;
    logic [7:0]        addr_lo;
    logic [7:0]        rd_q;
    logic [addr_w-9:0] block;
    logic [addr_w-1:0] mem_addr;
    logic              mem_we;
    logic [7:0]        mem [0:(1 << addr_w) - 1];

    // Edges seen on the synchronized lines
    assign clk_rise  = sync_s.clk && !line_d.clk;
    assign clk_fall  = !sync_s.clk && line_d.clk;
    assign start_det = sync_s.clk && line_d.clk && line_d.data && !sync_s.data;
    assign stop_det  = sync_s.clk && line_d.clk && !line_d.data && sync_s.data;

    // Falling clk after the 8th and after the 9th rising edge
    assign byte_end  = clk_fall && (bit_cnt == 4'd8) && (state != s_idle);
    assign slot_end  = clk_fall && (bit_cnt == 4'd9) && (state != s_idle);
    assign send_step = clk_fall && (state == s_send) && (bit_cnt != 4'd0) && (bit_cnt < 4'd8);

    assign code_ok  = (sh[7:4] == dev_code);
    assign mem_addr = {block, addr_lo};
    assign mem_we   = byte_end && (state == s_data);

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_m   <= '1;
            sync_s   <= '1;
            line_d   <= '1;
            state    <= s_idle;
            bit_cnt  <= 4'd0;
            data_low <= 1'b0;
        end
        else
        begin
            sync_m <= line;
            sync_s <= sync_m;
            line_d <= sync_s;
            if (start_det)
            begin
                state    <= s_ctrl;
                bit_cnt  <= 4'd0;
                data_low <= 1'b0;
            end
            else if (stop_det)
            begin
                state    <= s_idle;
                bit_cnt  <= 4'd0;
                data_low <= 1'b0;
            end
            else if (state != s_idle)
            begin
                if (clk_rise && bit_cnt != 4'd9)
                    bit_cnt <= bit_cnt + 4'd1;
                if (byte_end)
                begin
                    case (state)
                        s_ctrl:
                        begin
                            // Wrong device code, stay off the bus until next start
                            if (!code_ok)
                                state <= s_idle;
                            else
                                state <= sh[0] ? s_send : s_addr;
                            data_low <= code_ok;
                        end
                        s_addr:
                        begin
                            data_low <= 1'b1;
                            state    <= s_data;
                        end
                        s_data:
                        begin
                            data_low <= 1'b1;
                            state    <= s_wait;
                        end
                        s_send:
                        begin
                            // Master's ack slot
                            data_low <= 1'b0;
                            state    <= s_wait;
                        end
                        default:
                            data_low <= 1'b0;
                    endcase
                end
                else if (slot_end)
                begin
                    bit_cnt  <= 4'd0;
                    data_low <= (state == s_send) ? !rd_q[7] : 1'b0;
                end
                else if (send_step)
                begin
                    data_low <= !out_sh[7];
                end
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (clk_rise)
            sh <= {sh[6:0], sync_s.data};
        if (byte_end && state == s_ctrl && code_ok)
            block <= sh[3:1];
        if (byte_end && state == s_addr)
            addr_lo <= sh;
        if (slot_end && state == s_send)
            out_sh <= {rd_q[6:0], 1'b0};
        else if (send_step)
            out_sh <= {out_sh[6:0], 1'b0};
    end

    // Storage array with registered read
    always_ff @(posedge scl)
    begin
        if (mem_we)
            mem[mem_addr] <= sh;
        rd_q <= mem[mem_addr];
    end

endmodule

//--- rtl/eeprom_subsys.sv
`timescale 1ns/1ps

module eeprom_subsys
    import eeprom_pkg::*;
#(
    parameter int quarter_div = 4
)
(
    input  logic        scl,
    input  logic        arst_n,
    input  eeprom_cmd_t cmd,
    input  logic        cmd_valid,
    output logic        busy,
    output eeprom_rsp_t rsp,
    output logic        done
);

    bit_op_e    bit_op;
    logic       bit_in;
    logic       bit_go;
    logic       bit_out;
    logic       bit_done;
    bus_drive_t eng_drive;
    bus_line_t  line;
    logic       slave_data_low;

    // Wired-AND bus, lines float high unless pulled
    assign line.clk  = ~eng_drive.clk_low;
    assign line.data = ~(eng_drive.data_low | slave_data_low);

    eeprom_master i_master (
        .scl       (scl),
        .arst_n    (arst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .busy      (busy),
        .rsp       (rsp),
        .done      (done),
        .bit_op    (bit_op),
        .bit_in    (bit_in),
        .bit_go    (bit_go),
        .bit_out   (bit_out),
        .bit_done  (bit_done)
    );

    i2c_bit_engine #(
        .quarter_div (quarter_div)
    ) i_bit_engine (
        .scl      (scl),
        .arst_n   (arst_n),
        .bit_op   (bit_op),
        .bit_in   (bit_in),
        .bit_go   (bit_go),
        .drive    (eng_drive),
        .line     (line),
        .bit_out  (bit_out),
        .bit_done (bit_done)
    );

    eeprom_slave i_slave (
        .scl      (scl),
        .arst_n   (arst_n),
        .line     (line),
        .data_low (slave_data_low)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 4
)
(
    output logic scl,
    output logic arst_n
);

    initial
    begin
        scl = 1'b0;
        forever #(period_ns / 2.0) scl = ~scl;
    end

    // Release away from the rising edge
    initial
    begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge scl);
        @(negedge scl);
        arst_n = 1'b1;
    end

endmodule

//--- sim/tb_eeprom.sv
`timescale 1ns/1ps

module tb_eeprom
    import eeprom_pkg::*;
;

    localparam int quarter_div = 4;
    localparam int n_trans     = 80;
    localparam int wd_cycles   = n_trans * 800 + 2000;
    localparam int done_limit  = 1000;

    logic        scl;
    logic        arst_n;
    eeprom_cmd_t cmd;
    logic        cmd_valid;
    logic        busy;
    eeprom_rsp_t rsp;
    logic        done;

    logic [31:0] lcg_state;
    logic [7:0]  shadow [0:(1 << addr_w) - 1];
    bit          written [0:(1 << addr_w) - 1];

    tb_clock #(
        .period_ns    (10),
        .reset_cycles (4)
    ) i_clock (
        .scl    (scl),
        .arst_n (arst_n)
    );

    eeprom_subsys #(
        .quarter_div (quarter_div)
    ) i_eeprom_subsys (
        .scl       (scl),
        .arst_n    (arst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .busy      (busy),
        .rsp       (rsp),
        .done      (done)
    );

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input string name, input eeprom_rsp_t got, input eeprom_rsp_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s rdata=%h ack_ok=%h expected rdata=%h ack_ok=%h",
                     name, got.rdata, got.ack_ok, exp.rdata, exp.ack_ok);
            report_fail("Response mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            report_fail("Control level mismatch");
        end
    endtask

    // One-cycle command strobe
    task automatic strobe(input eeprom_cmd_t c);
        @(posedge scl);
        cmd       <= c;
        cmd_valid <= 1'b1;
        @(posedge scl);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_done(input string name, input eeprom_rsp_t exp);
        bit seen;
        seen = 0;
        for (int i = 0; i < done_limit && !seen; i++)
        begin
            @(negedge scl);
            if (done)
                seen = 1;
            else
                check_bit("busy", busy, 1'b1);
        end
        if (!seen)
            report_fail("No done pulse arrived within the expected time");
        check_bit("busy", busy, 1'b0);
        check_rsp(name, rsp, exp);
        @(negedge scl);
        check_bit("done", done, 1'b0);
    endtask

    task automatic write_byte(input logic [addr_w-1:0] a, input logic [7:0] d);
        eeprom_cmd_t c;
        c.write = 1'b1;
        c.addr  = a;
        c.wdata = d;
        strobe(c);
        wait_done("write rsp", eeprom_rsp_t'{rdata: 8'h00, ack_ok: 1'b1});
        shadow[a]  = d;
        written[a] = 1;
    endtask

    task automatic read_byte(input logic [addr_w-1:0] a);
        eeprom_cmd_t c;
        c.write = 1'b0;
        c.addr  = a;
        c.wdata = 8'h00;
        strobe(c);
        wait_done("read rsp", eeprom_rsp_t'{rdata: shadow[a], ack_ok: 1'b1});
    endtask

    task automatic test_idle();
        repeat (20)
        begin
            @(negedge scl);
            check_bit("busy", busy, 1'b0);
            check_bit("done", done, 1'b0);
        end
    endtask

    task automatic test_write_read();
        write_byte(11'h123, 8'hA5);
        read_byte(11'h123);
    endtask

    // Same low byte in every block
    task automatic test_blocks();
        for (int b = 0; b < 8; b++)
            write_byte({3'(b), 8'h5A}, 8'(8'h10 + b * 8'h11));
        for (int b = 0; b < 8; b++)
            read_byte({3'(b), 8'h5A});
    endtask

    task automatic test_random();
        logic [15:0] r;
        for (int i = 0; i < 20; i++)
        begin
            r = next_rand();
            // Small address pool so some writes overwrite
            write_byte({r[10:8], 6'h15, r[1:0]}, 8'(next_rand() >> 8));
        end
        for (int a = 0; a < (1 << addr_w); a++)
            if (written[a])
                read_byte(addr_w'(a));
    endtask

    task automatic test_busy_strobe();
        eeprom_cmd_t first;
        eeprom_cmd_t second;
        first.write  = 1'b1;
        first.addr   = 11'h2C7;
        first.wdata  = 8'h3E;
        second.write = 1'b1;
        second.addr  = 11'h2C7;
        second.wdata = 8'hC1;
        strobe(first);
        repeat (5) @(negedge scl);
        strobe(second);
        wait_done("write rsp", eeprom_rsp_t'{rdata: 8'h00, ack_ok: 1'b1});
        shadow[first.addr]  = first.wdata;
        written[first.addr] = 1;
        repeat (800)
        begin
            @(negedge scl);
            if (done)
                report_fail("A second done arrived for a strobe sent while busy");
            check_bit("busy", busy, 1'b0);
        end
        read_byte(first.addr);
    endtask

    initial
    begin
        repeat (wd_cycles) @(posedge scl);
        report_fail("Watchdog expired before the tests finished");
    end

    initial
    begin
        cmd       = '0;
        cmd_valid = 1'b0;
        lcg_state = 32'd50;
        for (int a = 0; a < (1 << addr_w); a++)
            written[a] = 0;
        @(posedge arst_n);
        test_idle();
        test_write_read();
        test_blocks();
        test_random();
        test_busy_strobe();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tb.f
rtl/eeprom_pkg.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_master.sv
rtl/eeprom_slave.sv
rtl/eeprom_subsys.sv
sim/tb_clock.sv
sim/tb_eeprom.sv
